//--- Bender.yml
package:
  name: cp0

export_include_dirs:
  - rtl

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/cp0_pkg.sv
      - rtl/cp_credit_queue.sv
      - rtl/cp0_csr_file.sv
      - rtl/cp_rsp_sender.sv
      - rtl/cp0_top.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - tests/cp0_tb.sv

//--- compile.f
+incdir+rtl
rtl/cp0_pkg.sv
rtl/cp_credit_queue.sv
rtl/cp0_csr_file.sv
rtl/cp_rsp_sender.sv
rtl/cp0_top.sv
tests/cp0_tb.sv

//--- rtl/cp0_csr_file.sv
/* Machine-mode CSR file: command decode, CSR read/modify/write,
   counters and trap control outputs */
`timescale 1ns/1ps
`default_nettype none

`include "cp0_defs.svh"

module cp0_csr_file (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 cmd_avail,
    input  cp0_pkg::cp_cmd_t     cmd,
    output logic                 cmd_pop,
    input  logic                 rsp_space,
    output logic                 rsp_push,
    output cp0_pkg::cp_rsp_t     rsp,
    input  logic                 interrupt_pending,
    output logic                 trap_enable,
    output logic [`CP0_XLEN-1:0] trap_vector,
    output logic                 privilege_mode
);

    localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

    logic [6:0]           opcode;
    logic [2:0]           funct3;
    logic [11:0]          csr_addr;
    logic [4:0]           rs1;
    logic [4:0]           zimm;
    logic                 is_imm;
    logic                 src_nz;
    logic [`CP0_XLEN-1:0] operand;

    logic [`CP0_XLEN-1:0] mstatus;
    logic [`CP0_XLEN-1:0] mie;
    logic [`CP0_XLEN-1:0] mtvec;
    logic [`CP0_XLEN-1:0] mscratch;
    logic [`CP0_XLEN-1:0] mepc;
    logic [`CP0_XLEN-1:0] mcause;
    logic [`CP0_XLEN-1:0] mtval;
    logic [`CP0_XLEN-1:0] cycle;
    logic [`CP0_XLEN-1:0] instret;
    logic                 mtip;

    logic [`CP0_XLEN-1:0] rdata;
    logic [`CP0_XLEN-1:0] wdata;
    logic                 addr_ok;
    logic                 read_only;
    logic                 op_ok;
    logic                 wr_req;
    logic                 exc;
    logic                 exec;
    logic                 wr_en;

    assign opcode   = cmd.instr[6:0];
    assign funct3   = cmd.instr[14:12];
    assign rs1      = cmd.instr[19:15];
    assign zimm     = cmd.instr[19:15]; // Same field, immediate forms
    assign csr_addr = cmd.instr[31:20];

    assign is_imm  = funct3[2];
    assign src_nz  = (rs1 != 5'd0); // x0 or zimm 0, same field
    assign operand = is_imm ? {{(`CP0_XLEN-5){1'b0}}, zimm} : cmd.data;

    // CSR read mux and address classification
    always_comb begin
        rdata     = '0;
        addr_ok   = 1'b1;
        read_only = 1'b0;
        case (csr_addr)
            cp0_pkg::CSR_MSTATUS:  rdata = mstatus;
            cp0_pkg::CSR_MIE:      rdata = mie;
            cp0_pkg::CSR_MTVEC:    rdata = mtvec;
            cp0_pkg::CSR_MSCRATCH: rdata = mscratch;
            cp0_pkg::CSR_MEPC:     rdata = mepc;
            cp0_pkg::CSR_MCAUSE:   rdata = mcause;
            cp0_pkg::CSR_MTVAL:    rdata = mtval;
            cp0_pkg::CSR_MISA: begin
                rdata     = `CP0_MISA_RESET;
                read_only = 1'b1;
            end
            cp0_pkg::CSR_MIP: begin
                rdata     = {{(`CP0_XLEN-8){1'b0}}, mtip, 7'b0};
                read_only = 1'b1;
            end
            cp0_pkg::CSR_CYCLE: begin
                rdata     = cycle;
                read_only = 1'b1;
            end
            cp0_pkg::CSR_INSTRET: begin
                rdata     = instret;
                read_only = 1'b1;
            end
            default: addr_ok = 1'b0;
        endcase
    end

    // New value: replace, set or clear
    always_comb begin
        op_ok  = 1'b1;
        wr_req = 1'b0;
        wdata  = rdata;
        case (funct3)
            cp0_pkg::CSR_RW, cp0_pkg::CSR_RWI: begin
                wr_req = 1'b1; // Always writes, even from x0
                wdata  = operand;
            end
            cp0_pkg::CSR_RS, cp0_pkg::CSR_RSI: begin
                wr_req = src_nz;
                wdata  = rdata | operand;
            end
            cp0_pkg::CSR_RC, cp0_pkg::CSR_RCI: begin
                wr_req = src_nz;
                wdata  = rdata & ~operand;
            end
            default: op_ok = 1'b0; // funct3 0 and 3'b100
        endcase
    end

    assign exc = (opcode != OPC_SYSTEM) || !op_ok || !addr_ok || (read_only && wr_req);

    // One command per cycle whenever the response can be taken
    assign exec     = cmd_avail && rsp_space;
    assign cmd_pop  = exec;
    assign rsp_push = exec;
    assign wr_en    = exec && !exc && wr_req;

    assign rsp.rdata = exc ? '0 : rdata; // Excepting commands return zero
    assign rsp.exc   = exc;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mstatus  <= '0;
            mie      <= '0;
            mtvec    <= '0;
            mscratch <= '0;
            mepc     <= '0;
            mcause   <= '0;
            mtval    <= '0;
            cycle    <= '0;
            instret  <= '0;
            mtip     <= 1'b0;
        end else begin
            cycle <= cycle + 1'b1;
            mtip  <= interrupt_pending;
            // Only commands that complete without exception retire
            if (exec && !exc) begin
                instret <= instret + 1'b1;
            end
            if (wr_en) begin
                case (csr_addr)
                    cp0_pkg::CSR_MSTATUS:  mstatus  <= wdata;
                    cp0_pkg::CSR_MIE:      mie      <= wdata;
                    cp0_pkg::CSR_MTVEC:    mtvec    <= wdata;
                    cp0_pkg::CSR_MSCRATCH: mscratch <= wdata;
                    cp0_pkg::CSR_MEPC:     mepc     <= wdata;
                    cp0_pkg::CSR_MCAUSE:   mcause   <= wdata;
                    cp0_pkg::CSR_MTVAL:    mtval    <= wdata;
                    default: ;
                endcase
            end
        end
    end

    assign trap_enable    = interrupt_pending && mie[7] && mstatus[3];
    assign trap_vector    = mtvec; // Direct mode only
    assign privilege_mode = mstatus[3];

    // Every popped command leaves exactly one response behind
    a_push_matches_pop: assert property (
        @(posedge clk) disable iff (!rst_n) rsp_push == cmd_pop
    );

endmodule

`default_nettype wire

//--- rtl/cp0_defs.svh
/* Widths, queue depths and reset constants for the CP0 coprocessor */
`ifndef CP0_DEFS_SVH
`define CP0_DEFS_SVH

`default_nettype none

// Datapath widths
`define CP0_XLEN 64
`define CP0_ILEN 32

// Command queue depth, also the producer's starting credit count
`define CP0_CMD_DEPTH 4

`define CP0_RSP_DEPTH 4

// Buffer slots on the consumer side of the response channel
`define CP0_RSP_CREDITS 2

// RV64I with a few extensions
`define CP0_MISA_RESET 64'h8000_0000_0014_1101

`default_nettype wire

`endif

//--- rtl/cp0_pkg.sv
/* CP0 package: CSR addresses, CSR operation codes and the
   command and response payload structs */
`default_nettype none

`include "cp0_defs.svh"

package cp0_pkg;

    // Implemented machine-mode CSRs
    typedef enum logic [11:0] {
        CSR_MSTATUS  = 12'h300,
        CSR_MISA     = 12'h301,
        CSR_MIE      = 12'h304,
        CSR_MTVEC    = 12'h305,
        CSR_MSCRATCH = 12'h340,
        CSR_MEPC     = 12'h341,
        CSR_MCAUSE   = 12'h342,
        CSR_MTVAL    = 12'h343,
        CSR_MIP      = 12'h344,
        CSR_CYCLE    = 12'hC00,
        CSR_INSTRET  = 12'hC02
    } csr_addr_t;

    // funct3 of the SYSTEM opcode, bit 2 selects the immediate form
    typedef enum logic [2:0] {
        CSR_RW  = 3'b001,
        CSR_RS  = 3'b010,
        CSR_RC  = 3'b011,
        CSR_RWI = 3'b101,
        CSR_RSI = 3'b110,
        CSR_RCI = 3'b111
    } csr_op_t;

    typedef struct packed {
        logic [`CP0_ILEN-1:0] instr;
        logic [`CP0_XLEN-1:0] data; // rs1 value from the core
    } cp_cmd_t;

    typedef struct packed {
        logic [`CP0_XLEN-1:0] rdata; // Old CSR value
        logic                 exc;
    } cp_rsp_t;

endpackage

`default_nettype wire

//--- rtl/cp0_top.sv
/* CP0 top level: command queue, CSR file, response queue and sender */
`timescale 1ns/1ps
`default_nettype none

`include "cp0_defs.svh"

module cp0_top (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 cmd_valid,
    input  logic [`CP0_ILEN-1:0] cmd_instr,
    input  logic [`CP0_XLEN-1:0] cmd_data,
    output logic                 cmd_credit,
    output logic                 rsp_valid,
    output logic [`CP0_XLEN-1:0] rsp_rdata,
    output logic                 rsp_exc,
    input  logic                 rsp_credit,
    input  logic                 interrupt_pending,
    output logic                 trap_enable,
    output logic [`CP0_XLEN-1:0] trap_vector,
    output logic                 privilege_mode
);

    cp0_pkg::cp_cmd_t cmd_in;
    cp0_pkg::cp_cmd_t cmd_head;
    cp0_pkg::cp_rsp_t rsp_in;
    cp0_pkg::cp_rsp_t rsp_head;

    logic cmd_avail;
    logic cmd_pop;
    logic rsp_push;
    logic rsp_full;
    logic rsp_space;
    logic rsp_avail;
    logic rsp_pop;

    assign cmd_in.instr = cmd_instr;
    assign cmd_in.data  = cmd_data;
    assign rsp_space    = !rsp_full;

    // Producer credits keep this queue from overflowing
    cp_credit_queue #(
        .payload_t (cp0_pkg::cp_cmd_t),
        .DEPTH     (`CP0_CMD_DEPTH)
    ) cmd_queue (
        .clk       (clk),
        .rst_n     (rst_n),
        .push      (cmd_valid),
        .push_data (cmd_in),
        .pop       (cmd_pop),
        .head      (cmd_head),
        .not_empty (cmd_avail),
        .full      (),
        .credit    (cmd_credit)
    );

    cp0_csr_file csr_file (
        .clk               (clk),
        .rst_n             (rst_n),
        .cmd_avail         (cmd_avail),
        .cmd               (cmd_head),
        .cmd_pop           (cmd_pop),
        .rsp_space         (rsp_space),
        .rsp_push          (rsp_push),
        .rsp               (rsp_in),
        .interrupt_pending (interrupt_pending),
        .trap_enable       (trap_enable),
        .trap_vector       (trap_vector),
        .privilege_mode    (privilege_mode)
    );

    cp_credit_queue #(
        .payload_t (cp0_pkg::cp_rsp_t),
        .DEPTH     (`CP0_RSP_DEPTH)
    ) rsp_queue (
        .clk       (clk),
        .rst_n     (rst_n),
        .push      (rsp_push),
        .push_data (rsp_in),
        .pop       (rsp_pop),
        .head      (rsp_head),
        .not_empty (rsp_avail),
        .full      (rsp_full),
        .credit    ()
    );

    cp_rsp_sender rsp_sender (
        .clk        (clk),
        .rst_n      (rst_n),
        .rsp_avail  (rsp_avail),
        .rsp_head   (rsp_head),
        .rsp_pop    (rsp_pop),
        .rsp_valid  (rsp_valid),
        .rsp_rdata  (rsp_rdata),
        .rsp_exc    (rsp_exc),
        .rsp_credit (rsp_credit)
    );

endmodule

`default_nettype wire

//--- rtl/cp_credit_queue.sv
/* Credit-returning FIFO for any packed payload type */
`timescale 1ns/1ps
`default_nettype none

module cp_credit_queue #(
    parameter type payload_t = logic,
    parameter int  DEPTH     = 4
) (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     push,
    input  payload_t push_data,
    input  logic     pop,
    output payload_t head,
    output logic     not_empty,
    output logic     full,
    output logic     credit
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    payload_t         mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;

    // Wraps at DEPTH, so non power of two depths work too
    function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] ptr);
        logic [PTR_W-1:0] nxt;
        nxt = (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
        return nxt;
    endfunction

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
            credit <= 1'b0;
        end else begin
            if (push) begin
                wr_ptr <= ptr_next(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= ptr_next(rd_ptr);
            end
            count  <= count + CNT_W'(push) - CNT_W'(pop);
            credit <= pop; // One credit back per freed slot
        end
    end

    assign head      = mem[rd_ptr];
    assign not_empty = (count != '0);
    assign full      = (count == CNT_W'(DEPTH));

    // The producer's credit count must keep it out of a full queue
    a_no_overflow: assert property (
        @(posedge clk) disable iff (!rst_n) full |-> !push
    );

    a_no_underflow: assert property (
        @(posedge clk) disable iff (!rst_n) !not_empty |-> !pop
    );

endmodule

`default_nettype wire

//--- rtl/cp_rsp_sender.sv
/* Response sender: consumer credit counter and response emission */
`timescale 1ns/1ps
`default_nettype none

`include "cp0_defs.svh"

module cp_rsp_sender (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 rsp_avail,
    input  cp0_pkg::cp_rsp_t     rsp_head,
    output logic                 rsp_pop,
    output logic                 rsp_valid,
    output logic [`CP0_XLEN-1:0] rsp_rdata,
    output logic                 rsp_exc,
    input  logic                 rsp_credit
);

    localparam int CRED_W = $clog2(`CP0_RSP_CREDITS + 1);
    localparam logic [CRED_W-1:0] CRED_MAX = CRED_W'(`CP0_RSP_CREDITS);

    logic [CRED_W-1:0] credits;
    logic              send;

    assign send = rsp_avail && (credits != '0);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            credits <= CRED_MAX;
        end else if (rsp_credit && !send) begin
            credits <= credits + 1'b1;
        end else if (!rsp_credit && send) begin
            credits <= credits - 1'b1;
        end
        // Return and send together leave the count as is
    end

    assign rsp_pop   = send;
    assign rsp_valid = send;
    assign rsp_rdata = rsp_head.rdata;
    assign rsp_exc   = rsp_head.exc;

    // Consumer must not return more credits than it was granted
    a_credit_overflow: assert property (
        @(posedge clk) disable iff (!rst_n)
        (rsp_credit && !send) |-> (credits < CRED_MAX)
    );

    a_credit_underflow: assert property (
        @(posedge clk) disable iff (!rst_n) rsp_valid |-> (credits != '0)
    );

endmodule

`default_nettype wire

//--- tests/cp0_tb.sv
/* Testbench for cp0_top: CSR reference model, credit bookkeeping,
   stimulus and concurrent checks on responses and trap outputs */
`timescale 1ns/1ps
`include "cp0_defs.svh"
`default_nettype none

module cp0_tb;

    localparam int         TIMEOUT    = 500;
    localparam int         KIND_EXACT = 0;
    localparam int         KIND_CYCLE = 1; // Value unknown, only has to rise
    localparam logic [6:0] OPC_SYSTEM = 7'h73;

    localparam logic [11:0] WR_ADDRS [7] = '{
        cp0_pkg::CSR_MSTATUS, cp0_pkg::CSR_MIE, cp0_pkg::CSR_MTVEC, cp0_pkg::CSR_MSCRATCH,
        cp0_pkg::CSR_MEPC, cp0_pkg::CSR_MCAUSE, cp0_pkg::CSR_MTVAL
    };
    localparam logic [11:0] ALL_ADDRS [12] = '{
        cp0_pkg::CSR_MSTATUS, cp0_pkg::CSR_MIE, cp0_pkg::CSR_MTVEC, cp0_pkg::CSR_MSCRATCH,
        cp0_pkg::CSR_MEPC, cp0_pkg::CSR_MCAUSE, cp0_pkg::CSR_MTVAL, cp0_pkg::CSR_MISA,
        cp0_pkg::CSR_MIP, cp0_pkg::CSR_CYCLE, cp0_pkg::CSR_INSTRET, 12'h7C0
    };
    localparam logic [2:0] VALID_OPS [6] = '{3'b001, 3'b010, 3'b011, 3'b101, 3'b110, 3'b111};

    logic                 clk;
    logic                 rst_n;
    logic                 cmd_valid;
    logic [`CP0_ILEN-1:0] cmd_instr;
    logic [`CP0_XLEN-1:0] cmd_data;
    logic                 cmd_credit;
    logic                 rsp_valid;
    logic [`CP0_XLEN-1:0] rsp_rdata;
    logic                 rsp_exc;
    logic                 rsp_credit;
    logic                 interrupt_pending;
    logic                 trap_enable;
    logic [`CP0_XLEN-1:0] trap_vector;
    logic                 privilege_mode;

    logic [`CP0_XLEN-1:0] m_csr [4096]; // Writable CSRs of the model
    logic [`CP0_XLEN-1:0] m_instret;
    logic [`CP0_XLEN-1:0] exp_rdata_q [$];
    logic                 exp_exc_q [$];
    int                   exp_kind_q [$];
    logic [`CP0_XLEN-1:0] head_rdata;
    logic                 head_exc;
    int                   head_kind;
    logic                 head_ok;
    logic [`CP0_XLEN-1:0] last_cycle;
    logic [`CP0_XLEN-1:0] exp_mtvec;
    logic                 exp_mie7;
    logic                 exp_mstatus3;
    int                   cmd_cred;   // Credits held toward the command queue
    int                   buf_fill;   // Consumer slots in use
    int                   stall_left;
    logic                 random_pace;
    logic                 drained;    // No command in flight, model equals DUT

    cp0_top dut0 (
        .clk               (clk),
        .rst_n             (rst_n),
        .cmd_valid         (cmd_valid),
        .cmd_instr         (cmd_instr),
        .cmd_data          (cmd_data),
        .cmd_credit        (cmd_credit),
        .rsp_valid         (rsp_valid),
        .rsp_rdata         (rsp_rdata),
        .rsp_exc           (rsp_exc),
        .rsp_credit        (rsp_credit),
        .interrupt_pending (interrupt_pending),
        .trap_enable       (trap_enable),
        .trap_vector       (trap_vector),
        .privilege_mode    (privilege_mode)
    );

    always #2 clk = ~clk;

    task automatic stop_run(input string why);
        $display("%s", why);
        $display("Simulation failed");
        $fatal(1);
    endtask

    task automatic report_mismatch(input string sig, input logic [63:0] exp_v,
                                   input logic [63:0] got_v);
        $display("error, %0t, %s, expected %h, got %h", $time, sig, exp_v, got_v);
        $display("Simulation failed");
        $fatal(1);
    endtask

    function automatic logic [31:0] csr_instr(input logic [2:0] f3, input logic [11:0] addr,
                                              input logic [4:0] src);
        return {addr, src, f3, 5'd1, OPC_SYSTEM};
    endfunction

    task automatic refresh_head();
        head_ok = (exp_rdata_q.size() != 0);
        if (head_ok) begin
            head_rdata = exp_rdata_q[0];
            head_exc   = exp_exc_q[0];
            head_kind  = exp_kind_q[0];
        end
    endtask

    // In-order CSR model, queues the expected response
    task automatic model_exec(input logic [31:0] instr, input logic [63:0] data);
        logic [2:0]  f3;
        logic [4:0]  src;
        logic [11:0] addr;
        logic [63:0] old;
        logic [63:0] opnd;
        logic [63:0] nv;
        logic        known;
        logic        ro;
        logic        writes;
        logic        exc;
        int          kind;
        f3    = instr[14:12];
        src   = instr[19:15];
        addr  = instr[31:20];
        known = 1'b1;
        ro    = 1'b1;
        kind  = KIND_EXACT;
        old   = '0;
        case (addr)
            cp0_pkg::CSR_MISA:    old = `CP0_MISA_RESET;
            cp0_pkg::CSR_MIP:     old = {56'b0, interrupt_pending, 7'b0};
            cp0_pkg::CSR_CYCLE:   kind = KIND_CYCLE;
            cp0_pkg::CSR_INSTRET: old = m_instret;
            cp0_pkg::CSR_MSTATUS, cp0_pkg::CSR_MIE, cp0_pkg::CSR_MTVEC, cp0_pkg::CSR_MSCRATCH,
            cp0_pkg::CSR_MEPC, cp0_pkg::CSR_MCAUSE, cp0_pkg::CSR_MTVAL: begin
                old = m_csr[addr];
                ro  = 1'b0;
            end
            default: known = 1'b0;
        endcase
        opnd   = f3[2] ? {59'b0, src} : data;
        writes = (f3[1:0] == 2'b01) || (src != 5'd0); // Set and clear skip x0 or zimm 0
        case (f3[1:0])
            2'b01:   nv = opnd;
            2'b10:   nv = old | opnd;
            default: nv = old & ~opnd;
        endcase
        exc = (instr[6:0] != OPC_SYSTEM) || (f3[1:0] == 2'b00) || !known || (ro && writes);
        if (exc) begin
            old  = '0;
            kind = KIND_EXACT;
        end else begin
            m_instret = m_instret + 1'b1;
            if (writes && !ro) begin
                m_csr[addr] = nv;
            end
        end
        exp_rdata_q.push_back(old);
        exp_exc_q.push_back(exc);
        exp_kind_q.push_back(kind);
        exp_mie7     = m_csr[cp0_pkg::CSR_MIE][7];
        exp_mstatus3 = m_csr[cp0_pkg::CSR_MSTATUS][3];
        exp_mtvec    = m_csr[cp0_pkg::CSR_MTVEC];
        refresh_head();
    endtask

    task automatic issue(input logic [31:0] instr, input logic [63:0] data);
        int waited;
        waited = 0;
        @(negedge clk);
        cmd_valid = 1'b0;
        while (cmd_cred == 0) begin
            if (waited == TIMEOUT) stop_run("timed out waiting for a command credit");
            waited++;
            @(negedge clk);
        end
        drained   = 1'b0;
        cmd_valid = 1'b1;
        cmd_instr = instr;
        cmd_data  = data;
        cmd_cred--;
        model_exec(instr, data);
    endtask

    task automatic drain();
        int waited;
        waited = 0;
        @(negedge clk);
        cmd_valid = 1'b0;
        while (exp_rdata_q.size() != 0) begin
            if (waited == TIMEOUT) stop_run("timed out waiting for outstanding responses");
            waited++;
            @(negedge clk);
        end
        drained = 1'b1;
        repeat (2) @(negedge clk); // Let the trap checks see the settled state
    endtask

    task automatic random_cmd(input logic any_addr);
        logic [11:0] addr;
        logic [2:0]  f3;
        if (any_addr) begin
            addr = ALL_ADDRS[$urandom % 12];
            f3   = 3'($urandom);
        end else begin
            addr = WR_ADDRS[$urandom % 7];
            f3   = VALID_OPS[$urandom % 6];
        end
        issue(csr_instr(f3, addr, 5'($urandom % 4)), {$urandom, $urandom});
    endtask

    // Credit and expected queue bookkeeping
    always @(posedge clk) begin
        if (rst_n) begin
            if (cmd_credit) cmd_cred++;
            buf_fill = buf_fill + int'(rsp_valid) - int'(rsp_credit);
            if (rsp_valid && head_ok) begin
                if (head_kind == KIND_CYCLE) last_cycle = rsp_rdata;
                void'(exp_rdata_q.pop_front());
                void'(exp_exc_q.pop_front());
                void'(exp_kind_q.pop_front());
                refresh_head();
            end
        end
    end

    // Consumer: frees buffer slots, with long random stalls in paced mode
    always @(negedge clk) begin
        if (stall_left > 0) begin
            stall_left--;
        end else if (random_pace && ($urandom % 20 == 0)) begin
            stall_left = 10 + $urandom % 40;
        end
        rsp_credit = (buf_fill > 0) && (stall_left == 0) && (!random_pace || $urandom % 2 == 0);
    end

    a_rsp_expected: assert property (@(posedge clk) disable iff (!rst_n) rsp_valid |-> head_ok)
        else stop_run("response arrived with no command outstanding");
    a_rsp_exc: assert property (
        @(posedge clk) disable iff (!rst_n) rsp_valid |-> rsp_exc == head_exc
    ) else report_mismatch("rsp_exc", 64'($sampled(head_exc)), 64'($sampled(rsp_exc)));
    a_rsp_rdata: assert property (
        @(posedge clk) disable iff (!rst_n)
        (rsp_valid && head_kind == KIND_EXACT) |-> rsp_rdata == head_rdata
    ) else report_mismatch("rsp_rdata", $sampled(head_rdata), $sampled(rsp_rdata));
    a_cycle_rises: assert property (
        @(posedge clk) disable iff (!rst_n)
        (rsp_valid && head_kind == KIND_CYCLE) |-> rsp_rdata > last_cycle
    ) else stop_run("cycle read did not increase over the previous read");
    a_rsp_credit_bound: assert property (
        @(posedge clk) disable iff (!rst_n) rsp_valid |-> buf_fill < `CP0_RSP_CREDITS
    ) else stop_run("rsp_valid sent without a consumer credit");
    a_cmd_credit_bound: assert property (
        @(posedge clk) disable iff (!rst_n) cmd_credit |-> cmd_cred < `CP0_CMD_DEPTH
    ) else stop_run("cmd_credit returned more credits than were consumed");
    a_trap_enable: assert property (
        @(posedge clk) disable iff (!rst_n)
        drained |-> trap_enable == (interrupt_pending && exp_mie7 && exp_mstatus3)
    ) else report_mismatch("trap_enable", 64'(interrupt_pending && exp_mie7 && exp_mstatus3),
                           64'($sampled(trap_enable)));
    a_trap_vector: assert property (
        @(posedge clk) disable iff (!rst_n) drained |-> trap_vector == exp_mtvec
    ) else report_mismatch("trap_vector", $sampled(exp_mtvec), $sampled(trap_vector));
    a_privilege: assert property (
        @(posedge clk) disable iff (!rst_n) drained |-> privilege_mode == exp_mstatus3
    ) else report_mismatch("privilege_mode", 64'(exp_mstatus3), 64'($sampled(privilege_mode)));

    initial begin
        void'($urandom(32'hfca7));
        clk               = 1'b0;
        rst_n             = 1'b0;
        cmd_valid         = 1'b0;
        cmd_instr         = '0;
        cmd_data          = '0;
        rsp_credit        = 1'b0;
        interrupt_pending = 1'b0;
        foreach (m_csr[i]) m_csr[i] = '0;
        m_instret    = '0;
        last_cycle   = '0;
        exp_mtvec    = '0;
        exp_mie7     = 1'b0;
        exp_mstatus3 = 1'b0;
        cmd_cred     = `CP0_CMD_DEPTH;
        buf_fill     = 0;
        stall_left   = 0;
        random_pace  = 1'b0;
        drained      = 1'b0;
        refresh_head();
        repeat (3) @(negedge clk);
        rst_n = 1'b1;

        // Replace and read back every writable CSR
        for (int i = 0; i < 7; i++) begin
            issue(csr_instr(3'b001, WR_ADDRS[i], 5'd1), {$urandom, $urandom});
            issue(csr_instr(3'b010, WR_ADDRS[i], 5'd0), '0);
        end
        drain();

        // Interrupt enable path to trap_enable
        issue(csr_instr(3'b110, cp0_pkg::CSR_MSTATUS, 5'd8), '0);
        issue(csr_instr(3'b010, cp0_pkg::CSR_MIE, 5'd2), 64'h80);
        drain();
        interrupt_pending = 1'b1;
        drain();
        issue(csr_instr(3'b111, cp0_pkg::CSR_MSTATUS, 5'd8), '0);
        drain();

        repeat (40) random_cmd(1'b0);
        drain();

        // Exceptions, then reads proving no state changed
        issue(csr_instr(3'b010, 12'h7C0, 5'd0), '0);
        issue(csr_instr(3'b001, cp0_pkg::CSR_MISA, 5'd1), '1);
        issue(csr_instr(3'b101, cp0_pkg::CSR_CYCLE, 5'd3), '0);
        issue(csr_instr(3'b011, cp0_pkg::CSR_INSTRET, 5'd1), '1);
        issue(csr_instr(3'b110, cp0_pkg::CSR_MIP, 5'd4), '0);
        issue(csr_instr(3'b001, cp0_pkg::CSR_MSCRATCH, 5'd1) & ~32'h40, '1); // Opcode 0x33
        issue(csr_instr(3'b000, cp0_pkg::CSR_MSCRATCH, 5'd1), '1);
        issue(csr_instr(3'b100, cp0_pkg::CSR_MSCRATCH, 5'd1), '1);
        issue(csr_instr(3'b010, cp0_pkg::CSR_MISA, 5'd0), '0);
        issue(csr_instr(3'b110, cp0_pkg::CSR_MIP, 5'd0), '0);
        issue(csr_instr(3'b010, cp0_pkg::CSR_MSCRATCH, 5'd0), '0);
        drain();

        // Counters
        issue(csr_instr(3'b010, cp0_pkg::CSR_INSTRET, 5'd0), '0);
        repeat (3) random_cmd(1'b0);
        issue(csr_instr(3'b010, cp0_pkg::CSR_INSTRET, 5'd0), '0);
        issue(csr_instr(3'b010, cp0_pkg::CSR_CYCLE, 5'd0), '0);
        issue(csr_instr(3'b110, cp0_pkg::CSR_CYCLE, 5'd0), '0);
        drain();

        // Random consumer pacing with back-pressure
        random_pace = 1'b1;
        repeat (80) random_cmd(1'b1);
        drain();
        random_pace = 1'b0;
        drain();

        if (cmd_cred != `CP0_CMD_DEPTH) begin
            stop_run("command credits were not all returned");
        end else begin
            $display("Simulation completed successfully");
            $finish;
        end
    end

endmodule

`default_nettype wire
